/* dcache_pkg.sv */
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////

    // byte address width on both apb ports
    localparam int ADDR_W   = 16;

    // two-way set associative
    localparam int WAYS     = 2;

    // 16 sets, one word per line
    localparam int INDEX_W  = 4;
    localparam int SETS     = 1 << INDEX_W;

    // word aligned, low two address bits carry no information
    localparam int OFFSET_W = 2;

    // remaining upper address bits form the tag
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // cpu and memory word width
    localparam int DATA_W   = 32;

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////

    // set address into tag and data rams
    typedef logic [INDEX_W-1:0] index_t;

    // tag payload and compare value
    typedef logic [TAG_W-1:0]   tag_t;

    // data payload, cpu and memory data
    typedef logic [DATA_W-1:0]  word_t;

endpackage

/* bram.sv */
`timescale 1ns/1ps

module bram #(
    parameter type payload_t = dcache_pkg::word_t
) (
    input  logic               clk,
    input  logic               we,
    input  dcache_pkg::index_t waddr,
    input  payload_t           din,
    input  dcache_pkg::index_t raddr,
    output payload_t           dout
);
    import dcache_pkg::*;

    // one entry per set
    payload_t mem [SETS];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // registered read port
    // same-address write and read in one cycle gives the old entry
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

/* dcache_tagv.sv */
`timescale 1ns/1ps

module dcache_tagv (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dcache_pkg::index_t          rd_index,
    input  dcache_pkg::tag_t            lookup_tag,
    input  dcache_pkg::index_t          wr_index,
    input  dcache_pkg::tag_t            fill_tag,
    input  logic [dcache_pkg::WAYS-1:0] tag_we,
    output logic [dcache_pkg::WAYS-1:0] hit
);
    import dcache_pkg::*;

    // stored tag per way, valid one cycle after rd_index
    tag_t way_tag [WAYS];

    // one valid bit per set and way
    logic [WAYS-1:0][SETS-1:0] valid;

    // buffered read address, lines up with the ram output
    index_t lookup_index;

    ////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////

    // cleared on reset, set by a tag write to that way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (tag_we[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end
            end
        end
    end

    // same delay as the bram read port
    always_ff @(posedge clk) begin
        lookup_index <= rd_index;
    end

    ////////////////////////////////////////////////////////////
    // tag ways and compare
    ////////////////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        bram #(
            .payload_t (tag_t)
        ) i_tag_ram (
            .clk   (clk),
            .we    (tag_we[w]),
            .waddr (wr_index),
            .din   (fill_tag),
            .raddr (rd_index),
            .dout  (way_tag[w])
        );

        // tag match only counts on a valid line
        assign hit[w] = valid[w][lookup_index] && (way_tag[w] == lookup_tag);
    end

endmodule

/* dcache_data.sv */
`timescale 1ns/1ps

module dcache_data (
    input  logic                        clk,
    input  dcache_pkg::index_t          rd_index,
    input  dcache_pkg::index_t          wr_index,
    input  dcache_pkg::word_t           wr_data,
    input  logic [dcache_pkg::WAYS-1:0] data_we,
    input  logic [dcache_pkg::WAYS-1:0] hit,
    output dcache_pkg::word_t           rdata_hit
);
    import dcache_pkg::*;

    // registered word of each way for the set on rd_index
    word_t way_data [WAYS];

    ////////////////////////////////////////////////////////////
    // data ways
    ////////////////////////////////////////////////////////////

    // shared read index keeps data and tag outputs aligned
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        bram #(
            .payload_t (word_t)
        ) i_data_ram (
            .clk   (clk),
            .we    (data_we[w]),
            .waddr (wr_index),
            .din   (wr_data),
            .raddr (rd_index),
            .dout  (way_data[w])
        );
    end

    ////////////////////////////////////////////////////////////
    // hit way select
    ////////////////////////////////////////////////////////////

    // hit is one-hot or zero
    // no hit gives zero
    always_comb begin
        rdata_hit = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit[w]) begin
                rdata_hit = rdata_hit | way_data[w];
            end
        end
    end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,

    // cpu side apb completer
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [dcache_pkg::ADDR_W-1:0] paddr,
    input  dcache_pkg::word_t             pwdata,
    output dcache_pkg::word_t             prdata,
    output logic                          pready,

    // tag/valid and data arrays
    input  logic [dcache_pkg::WAYS-1:0]   hit,
    input  dcache_pkg::word_t             rdata_hit,
    output dcache_pkg::index_t            rd_index,
    output dcache_pkg::tag_t              lookup_tag,
    output dcache_pkg::index_t            wr_index,
    output dcache_pkg::tag_t              fill_tag,
    output dcache_pkg::word_t             wr_data,
    output logic [dcache_pkg::WAYS-1:0]   tag_we,
    output logic [dcache_pkg::WAYS-1:0]   data_we,

    // memory side apb requester
    output logic                          m_psel,
    output logic                          m_penable,
    output logic                          m_pwrite,
    output logic [dcache_pkg::ADDR_W-1:0] m_paddr,
    output dcache_pkg::word_t             m_pwdata,
    input  dcache_pkg::word_t             m_prdata,
    input  logic                          m_pready
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MSETUP,
        S_MACCESS,
        S_FINISH
    } state_t;

    state_t state;
    state_t state_nxt;

    // address fields of the current cpu transfer
    tag_t   cpu_tag;
    index_t cpu_index;

    // hit vector seen in the lookup cycle
    logic [WAYS-1:0] hit_q;

    // word returned by memory
    word_t mem_q;

    // per-set replacement bit naming the way to fill next
    logic [SETS-1:0] lru;

    logic            fill_way;
    logic [WAYS-1:0] fill_mask;

    logic read_hit;
    logic fill_en;
    logic wr_update;

    ////////////////////////////////////////////////////////////
    // address split and array controls
    ////////////////////////////////////////////////////////////

    // paddr holds through setup and access and drives the arrays directly
    assign cpu_tag   = paddr[ADDR_W-1 -: TAG_W];
    assign cpu_index = paddr[OFFSET_W +: INDEX_W];

    // read address presented in the setup cycle
    assign rd_index   = cpu_index;
    assign lookup_tag = cpu_tag;
    assign wr_index   = cpu_index;
    assign fill_tag   = cpu_tag;

    // fill way from the lru bit of this set
    assign fill_way = lru[cpu_index];

    always_comb begin
        fill_mask           = '0;
        fill_mask[fill_way] = 1'b1;
    end

    // read hit answers in the first access cycle
    assign read_hit = (state == S_LOOKUP) && !pwrite && (|hit);

    // read miss fill one cycle after memory returns
    assign fill_en = (state == S_FINISH) && !pwrite;

    // write hit updates the cached word on the memory ready cycle
    assign wr_update = (state == S_MACCESS) && m_pready && pwrite;

    assign tag_we  = fill_en ? fill_mask : '0;

    always_comb begin
        data_we = '0;
        if (fill_en) begin
            data_we = fill_mask;
        end else if (wr_update) begin
            data_we = hit_q;
        end
    end

    // cpu data on writes and memory word on fills
    assign wr_data = pwrite ? pwdata : mem_q;

    ////////////////////////////////////////////////////////////
    // cpu and memory apb outputs
    ////////////////////////////////////////////////////////////

    assign pready = read_hit || (state == S_FINISH);

    always_comb begin
        prdata = '0;
        if (state == S_LOOKUP) begin
            prdata = rdata_hit;
        end else if (state == S_FINISH) begin
            prdata = mem_q;
        end
    end

    // memory transfer mirrors the held cpu request
    assign m_psel    = (state == S_MSETUP) || (state == S_MACCESS);
    assign m_penable = (state == S_MACCESS);
    assign m_pwrite  = pwrite;
    assign m_paddr   = paddr;
    assign m_pwdata  = pwdata;

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            // wait for an apb setup phase
            S_IDLE: begin
                if (psel && !penable) begin
                    state_nxt = S_LOOKUP;
                end
            end
            // read hit ends here and everything else goes to memory
            S_LOOKUP: begin
                if (read_hit) begin
                    state_nxt = S_IDLE;
                end else begin
                    state_nxt = S_MSETUP;
                end
            end
            S_MSETUP: begin
                state_nxt = S_MACCESS;
            end
            // hold until memory ends its wait states
            S_MACCESS: begin
                if (m_pready) begin
                    state_nxt = S_FINISH;
                end
            end
            S_FINISH: begin
                state_nxt = S_IDLE;
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // lookup result and memory word
    always_ff @(posedge clk) begin
        if (state == S_LOOKUP) begin
            hit_q <= hit;
        end
        if ((state == S_MACCESS) && m_pready) begin
            mem_q <= m_prdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // lru bits
    ////////////////////////////////////////////////////////////

    // with two ways the bit points away from the last used way
    // writes leave it alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (read_hit) begin
            // a way 0 hit selects way 1 next and the reverse
            lru[cpu_index] <= hit[0];
        end else if (fill_en) begin
            lru[cpu_index] <= ~fill_way;
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // cpu side apb
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [dcache_pkg::ADDR_W-1:0] paddr,
    input  dcache_pkg::word_t             pwdata,
    output dcache_pkg::word_t             prdata,
    output logic                          pready,

    // memory side apb
    output logic                          m_psel,
    output logic                          m_penable,
    output logic                          m_pwrite,
    output logic [dcache_pkg::ADDR_W-1:0] m_paddr,
    output dcache_pkg::word_t             m_pwdata,
    input  dcache_pkg::word_t             m_prdata,
    input  logic                          m_pready
);
    import dcache_pkg::*;

    // controller to arrays
    index_t          rd_index;
    tag_t            lookup_tag;
    index_t          wr_index;
    tag_t            fill_tag;
    word_t           wr_data;
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] data_we;

    // arrays back to controller
    logic [WAYS-1:0] hit;
    word_t           rdata_hit;

    dcache_ctrl i_dcache_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .hit        (hit),
        .rdata_hit  (rdata_hit),
        .rd_index   (rd_index),
        .lookup_tag (lookup_tag),
        .wr_index   (wr_index),
        .fill_tag   (fill_tag),
        .wr_data    (wr_data),
        .tag_we     (tag_we),
        .data_we    (data_we),
        .m_psel     (m_psel),
        .m_penable  (m_penable),
        .m_pwrite   (m_pwrite),
        .m_paddr    (m_paddr),
        .m_pwdata   (m_pwdata),
        .m_prdata   (m_prdata),
        .m_pready   (m_pready)
    );

    dcache_tagv i_dcache_tagv (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index   (rd_index),
        .lookup_tag (lookup_tag),
        .wr_index   (wr_index),
        .fill_tag   (fill_tag),
        .tag_we     (tag_we),
        .hit        (hit)
    );

    dcache_data i_dcache_data (
        .clk        (clk),
        .rd_index   (rd_index),
        .wr_index   (wr_index),
        .wr_data    (wr_data),
        .data_we    (data_we),
        .hit        (hit),
        .rdata_hit  (rdata_hit)
    );

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int CYCLES_PER_LINE = 40;
    localparam int XFER_LIMIT      = 32;
    localparam int MEM_WORDS       = 1 << (ADDR_W - 2);

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    word_t             pwdata;
    word_t             prdata;
    logic              pready;
    logic              m_psel;
    logic              m_penable;
    logic              m_pwrite;
    logic [ADDR_W-1:0] m_paddr;
    word_t             m_pwdata;
    word_t             m_prdata;
    logic              m_pready;

    // pattern table with one entry per transfer
    string             pat_name  [$];
    string             pat_op    [$];
    logic [ADDR_W-1:0] pat_addr  [$];
    word_t             pat_wdata [$];
    word_t             pat_exp   [$];
    int                pat_mrd   [$];

    // backing memory and its transfer counters
    word_t       mem [MEM_WORDS];
    int          mem_reads;
    int          mem_writes;
    int          wait_left;
    int unsigned seed_val;

    int   errors;
    int   transfers;
    int   cycles;
    int   limit;
    logic loaded;

    dcache_top i_dcache_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_paddr   (m_paddr),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // memory model as an apb completer with random wait states
    ////////////////////////////////////////////////////////////

    initial begin
        seed_val = $urandom(32'h995bd1e3);
        // word at byte address a holds a ^ a5a50000
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[(ADDR_W-2)'(i)] = word_t'({(ADDR_W-2)'(i), 2'b00}) ^ 32'hA5A5_0000;
        end
        m_pready   = 1'b0;
        m_prdata   = '0;
        mem_reads  = 0;
        mem_writes = 0;
        wait_left  = 0;
        forever begin
            @(negedge clk);
            if (m_psel && !m_penable) begin
                // setup phase picks 0 to 3 wait states
                wait_left = int'($urandom % 4);
                m_pready  = 1'b0;
            end else if (m_psel && m_penable) begin
                if (wait_left > 0) begin
                    wait_left--;
                    m_pready = 1'b0;
                end else begin
                    // transfer completes on the next rising edge
                    if (m_pwrite) begin
                        mem[m_paddr[ADDR_W-1:2]] = m_pwdata;
                        mem_writes++;
                    end else begin
                        m_prdata = mem[m_paddr[ADDR_W-1:2]];
                        mem_reads++;
                    end
                    m_pready = 1'b1;
                end
            end else begin
                m_pready = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic show_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        $display("** Error %s: %s expected %0h actual %0h", test, what, exp, act);
        errors++;
    endtask

    // reset held over 4 rising edges
    task automatic apply_reset();
        @(negedge clk);
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        repeat (4) @(negedge clk);
        if (pready || m_psel || m_penable) begin
            $display("handshake outputs are not low during reset");
            errors++;
        end
        rst_n = 1'b1;
    endtask

    // one cpu apb transfer where waits counts access cycles without pready
    task automatic apb_transfer(input string test, input logic wr,
                                input logic [ADDR_W-1:0] addr, input word_t data,
                                output word_t rdata, output int waits, output logic ok);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        while (!pready && waits < XFER_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        ok    = pready;
        rdata = prdata;
        if (!ok) begin
            $display("transfer %s got no pready within %0d access cycles", test, XFER_LIMIT);
            errors++;
        end
        // back to idle after the completing edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // pattern columns are name op addr wdata expected mem_reads
    // lines that start with // are skipped
    task automatic load_patterns(output logic found);
        int                fd;
        int                code;
        int                c;
        string             tok;
        string             op;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        word_t             exp;
        int                mrd;
        logic              done;
        found = 1'b0;
        done  = 1'b0;
        fd    = $fopen("dcache_patterns.txt", "r");
        if (fd != 0) begin
            found = 1'b1;
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok == "//") begin
                    // rest of a comment line
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%s %h %h %h %d", op, addr, wdata, exp, mrd);
                    if (code != 5) begin
                        $display("pattern line %s is malformed", tok);
                        errors++;
                        done = 1'b1;
                    end else begin
                        pat_name.push_back(tok);
                        pat_op.push_back(op);
                        pat_addr.push_back(addr);
                        pat_wdata.push_back(wdata);
                        pat_exp.push_back(exp);
                        pat_mrd.push_back(mrd);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one pattern line and its checks
    task automatic run_pattern(input int i);
        int                rd0;
        int                wr0;
        word_t             rdata;
        int                waits;
        logic              ok;
        logic [ADDR_W-1:0] addr;
        rd0  = mem_reads;
        wr0  = mem_writes;
        addr = pat_addr[i];
        if (pat_op[i] == "reset") begin
            apply_reset();
        end else if (pat_op[i] == "read" || pat_op[i] == "write") begin
            apb_transfer(pat_name[i], pat_op[i] == "write", addr, pat_wdata[i],
                         rdata, waits, ok);
            transfers++;
            if (ok) begin
                if (pat_op[i] == "read") begin
                    if (rdata !== pat_exp[i]) begin
                        show_mismatch(pat_name[i], "read data", pat_exp[i], rdata);
                    end
                    // a hit answers in the first access cycle
                    if (pat_mrd[i] == 0 && waits != 0) begin
                        show_mismatch(pat_name[i], "access wait cycles", 0, waits);
                    end
                    if (mem_writes != wr0) begin
                        show_mismatch(pat_name[i], "memory writes", 0, mem_writes - wr0);
                    end
                end else begin
                    // write-through lands in memory
                    if (mem[addr[ADDR_W-1:2]] !== pat_exp[i]) begin
                        show_mismatch(pat_name[i], "memory word", pat_exp[i],
                                      mem[addr[ADDR_W-1:2]]);
                    end
                    if (mem_writes - wr0 != 1) begin
                        show_mismatch(pat_name[i], "memory writes", 1, mem_writes - wr0);
                    end
                end
                if (mem_reads - rd0 != pat_mrd[i]) begin
                    show_mismatch(pat_name[i], "memory reads", pat_mrd[i], mem_reads - rd0);
                end
            end
        end else begin
            $display("pattern %s has unknown op %s", pat_name[i], pat_op[i]);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        errors    = 0;
        transfers = 0;
        limit     = 0;
        load_patterns(loaded);
        if (!loaded) begin
            $display("cannot open dcache_patterns.txt");
            errors++;
        end else begin
            // one extra line's worth for the first reset
            limit = CYCLES_PER_LINE * (pat_name.size() + 1);
            apply_reset();
            for (int i = 0; i < pat_name.size(); i++) begin
                run_pattern(i);
            end
        end
        $display("transfers %0d  errors %0d", transfers, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // limit stays 0 until the patterns are loaded
    initial begin
        cycles = 0;
        @(posedge clk);
        while (limit == 0 || cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("transfers %0d  errors %0d", transfers, errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* dcache_patterns.txt */
// name op addr wdata expected mem_reads, all values hex except mem_reads
// expected is the read word for a read and the memory word after a write
// cold miss then hit
cold_miss      read  0104 00000000 A5A50104 1
repeat_hit     read  0104 00000000 A5A50104 0
// write-through on a hit and on a miss
wt_hit         write 0104 12345678 12345678 0
wt_hit_rd      read  0104 00000000 12345678 0
wt_miss        write 0208 CAFEF00D CAFEF00D 0
wt_miss_rd     read  0208 00000000 CAFEF00D 1
wt_miss_rd2    read  0208 00000000 CAFEF00D 0
// set 3 with A 000c, B 004c, C 008c
lru_a          read  000C 00000000 A5A5000C 1
lru_b          read  004C 00000000 A5A5004C 1
lru_a_hit      read  000C 00000000 A5A5000C 0
lru_c          read  008C 00000000 A5A5008C 1
lru_a_keep     read  000C 00000000 A5A5000C 0
lru_b_evicted  read  004C 00000000 A5A5004C 1
lru_c_evicted  read  008C 00000000 A5A5008C 1
lru_b_hit      read  004C 00000000 A5A5004C 0
// reset clears the valid bits, memory keeps its words
mid_reset      reset 0000 00000000 00000000 0
rst_miss       read  0104 00000000 12345678 1
rst_hit        read  0104 00000000 12345678 0
// mixed traffic over sets 5 6 8 and 15
mx_r1          read  0014 00000000 A5A50014 1
mx_w1          write 0018 0BADBEEF 0BADBEEF 0
mx_r2          read  0018 00000000 0BADBEEF 1
mx_w2          write 0014 11112222 11112222 0
mx_r3          read  0014 00000000 11112222 0
mx_r4          read  0054 00000000 A5A50054 1
mx_r5          read  0014 00000000 11112222 0
mx_w3          write 0054 33334444 33334444 0
mx_r6          read  0054 00000000 33334444 0
mx_r7          read  0094 00000000 A5A50094 1
mx_r8          read  0014 00000000 11112222 1
mx_r9          read  0094 00000000 A5A50094 0
mx_r10         read  0054 00000000 33334444 1
mx_r11         read  0020 00000000 A5A50020 1
mx_w4          write 0020 5555AAAA 5555AAAA 0
mx_r12         read  0020 00000000 5555AAAA 0
mx_r13         read  0018 00000000 0BADBEEF 0
mx_r14         read  3FFC 00000000 A5A53FFC 1
mx_r15         read  3FFC 00000000 A5A53FFC 0
mx_r16         read  FFFC 00000000 A5A5FFFC 1
mx_r17         read  3FFC 00000000 A5A53FFC 0
mx_r18         read  FFFC 00000000 A5A5FFFC 0

/* sources.f */
dcache_pkg.sv
bram.sv
dcache_tagv.sv
dcache_data.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dcache -f sources.f -o sim_dcache \
    > build.log 2>&1 \
    && ./obj_dir/sim_dcache 2>&1 | tee sim.log \
    && grep -q "^Simulation PASSED$" sim.log \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail, see build.log and sim.log"; exit 1; }
